//--- cart_mem_pkg.sv
package cart_mem_pkg;

  localparam int SYNC_DEPTH = 6;

  typedef logic [23:0] snes_addr_t;
  typedef logic [22:0] rom_word_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [3:0]  mem_delay_t;
  typedef logic [SYNC_DEPTH-1:0] sync_hist_t;

  // Each wait lasts one cycle more than its count
  localparam mem_delay_t ROM_RD_WAIT      = 4'd4;
  localparam mem_delay_t ROM_WR_WAIT1     = 4'd2;
  localparam mem_delay_t ROM_WR_WAIT2     = 4'd3;
  localparam mem_delay_t ROM_RD_WAIT_MCU  = 4'd6;
  localparam mem_delay_t ROM_WR_WAIT_MCU  = 4'd6;
  localparam mem_delay_t MCU_RECOVER_WAIT = 4'd2;

  typedef enum logic [4:0] {
    ST_IDLE,
    ST_SNES_RD_ADDR,
    ST_SNES_RD_WAIT,
    ST_SNES_RD_END,
    ST_SNES_WR_ADDR,
    ST_SNES_WR_WAIT1,
    ST_SNES_WR_DATA,
    ST_SNES_WR_WAIT2,
    ST_SNES_WR_END,
    ST_MCU_RD_ADDR,
    ST_MCU_RD_WAIT,
    ST_MCU_RD_WAIT2,
    ST_MCU_RD_END,
    ST_MCU_WR_ADDR,
    ST_MCU_WR_WAIT,
    ST_MCU_WR_WAIT2,
    ST_MCU_WR_END
  } arb_state_t;

endpackage

//--- snes_bus_sync.sv
`timescale 1ns/10ps

module snes_bus_sync (
  input  logic CLK2,
  input  logic rst_n,
  input  logic snes_write,
  input  logic snes_cpu_clk,
  output logic wr_start,
  output logic cycle_start,
  output logic cycle_end
);

  import cart_mem_pkg::*;

  sync_hist_t wr_hist;
  sync_hist_t clk_hist;

  logic wr_fall;
  logic clk_rise;
  logic clk_fall;

  // Fresh level after a full run of the opposite one
  assign wr_fall  = (wr_hist == {{(SYNC_DEPTH-1){1'b1}}, 1'b0});
  assign clk_rise = (clk_hist == {{(SYNC_DEPTH-1){1'b0}}, 1'b1});
  assign clk_fall = (clk_hist == {{(SYNC_DEPTH-1){1'b1}}, 1'b0});

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      wr_hist     <= '0;
      clk_hist    <= '0;
      wr_start    <= 1'b0;
      cycle_start <= 1'b0;
      cycle_end   <= 1'b0;
    end else begin
      wr_hist     <= {wr_hist[SYNC_DEPTH-2:0], snes_write};
      clk_hist    <= {clk_hist[SYNC_DEPTH-2:0], snes_cpu_clk};
      wr_start    <= wr_fall;
      cycle_start <= clk_rise;
      cycle_end   <= clk_fall;
    end
  end

endmodule

//--- mcu_req_ctrl.sv
`timescale 1ns/10ps

module mcu_req_ctrl (
  input  logic CLK2,
  input  logic rst_n,
  input  logic mcu_rrq,
  input  logic mcu_wrq,
  input  logic mcu_done,
  output logic mcu_rd_pend,
  output logic mcu_wr_pend,
  output logic mcu_rdy
);

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu_rrq) begin
      // Read wins when both pulse together
      mcu_rd_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_done) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

endmodule

//--- rom_arbiter.sv
`timescale 1ns/10ps

module rom_arbiter (
  input  logic                    CLK2,
  input  logic                    rst_n,
  input  logic                    wr_start,
  input  logic                    cycle_start,
  input  logic                    cycle_end,
  input  logic                    snes_cpu_clk,
  input  logic                    is_cart,
  input  logic                    is_writable,
  input  cart_mem_pkg::snes_addr_t mapped_addr,
  input  cart_mem_pkg::byte_t     snes_data_in,
  input  logic                    mcu_rd_pend,
  input  logic                    mcu_wr_pend,
  input  cart_mem_pkg::snes_addr_t mcu_addr,
  input  cart_mem_pkg::byte_t     mcu_dout,
  input  cart_mem_pkg::rom_word_t rom_data_in,
  input  logic                    rom_byte_sel,
  output cart_mem_pkg::snes_addr_t rom_addr_reg,
  output logic                    assert_snes_addr,
  output logic                    rom_we,
  output cart_mem_pkg::byte_t     rom_wr_data,
  output cart_mem_pkg::byte_t     snes_rd_data,
  output cart_mem_pkg::byte_t     mcu_din,
  output logic                    mcu_done
);

  import cart_mem_pkg::*;

  arb_state_t state;
  mem_delay_t mem_delay;
  logic       need_snes_addr;
  logic       rom_we_reg;
  logic       snes_wr_cycle;
  byte_t      rom_rd_byte;

  assign rom_rd_byte = rom_byte_sel ? rom_data_in[7:0] : rom_data_in[15:8];

  assign assert_snes_addr = snes_cpu_clk & need_snes_addr & is_cart;

  // Pass-through address never writes unless a console write owns the bus
  assign rom_we = rom_we_reg | (assert_snes_addr & ~snes_wr_cycle);

  assign mcu_done = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      need_snes_addr <= 1'b0;
    end else if (cycle_end) begin
      need_snes_addr <= 1'b1;
    end else if ((state == ST_SNES_RD_END) || (state == ST_SNES_WR_END)) begin
      need_snes_addr <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Arbitration FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state         <= ST_IDLE;
      mem_delay     <= '0;
      rom_we_reg    <= 1'b1;
      snes_wr_cycle <= 1'b0;
    end else if (cycle_start && is_cart) begin
      // Console always preempts
      state         <= ST_SNES_RD_ADDR;
      rom_we_reg    <= 1'b1;
      snes_wr_cycle <= 1'b0;
    end else if (wr_start && is_cart) begin
      state      <= ST_SNES_WR_ADDR;
      rom_we_reg <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (!assert_snes_addr && mcu_rd_pend) begin
            state <= ST_MCU_RD_ADDR;
          end else if (!assert_snes_addr && mcu_wr_pend) begin
            state <= ST_MCU_WR_ADDR;
          end
        end
        ST_SNES_RD_ADDR: begin
          state     <= ST_SNES_RD_WAIT;
          mem_delay <= ROM_RD_WAIT;
        end
        ST_SNES_RD_WAIT: begin
          mem_delay <= mem_delay - 4'd1;
          if (mem_delay == 4'd0) begin
            state <= ST_SNES_RD_END;
          end
        end
        ST_SNES_RD_END: begin
          state <= ST_IDLE;
        end
        ST_SNES_WR_ADDR: begin
          rom_we_reg    <= ~is_writable;
          snes_wr_cycle <= 1'b1;
          state         <= ST_SNES_WR_WAIT1;
          mem_delay     <= ROM_WR_WAIT1;
        end
        ST_SNES_WR_WAIT1: begin
          mem_delay <= mem_delay - 4'd1;
          if (mem_delay == 4'd0) begin
            state <= ST_SNES_WR_DATA;
          end
        end
        ST_SNES_WR_DATA: begin
          state     <= ST_SNES_WR_WAIT2;
          mem_delay <= ROM_WR_WAIT2;
        end
        ST_SNES_WR_WAIT2: begin
          mem_delay <= mem_delay - 4'd1;
          if (mem_delay == 4'd0) begin
            state <= ST_SNES_WR_END;
          end
        end
        ST_SNES_WR_END: begin
          state         <= ST_IDLE;
          rom_we_reg    <= 1'b1;
          snes_wr_cycle <= 1'b0;
        end
        ST_MCU_RD_ADDR: begin
          state     <= ST_MCU_RD_WAIT;
          mem_delay <= ROM_RD_WAIT_MCU;
        end
        ST_MCU_RD_WAIT: begin
          mem_delay <= mem_delay - 4'd1;
          if (mem_delay == 4'd0) begin
            state     <= ST_MCU_RD_WAIT2;
            mem_delay <= MCU_RECOVER_WAIT;
          end
        end
        ST_MCU_RD_WAIT2: begin
          mem_delay <= mem_delay - 4'd1;
          if (mem_delay == 4'd0) begin
            state <= ST_MCU_RD_END;
          end
        end
        ST_MCU_RD_END: begin
          state <= ST_IDLE;
        end
        ST_MCU_WR_ADDR: begin
          state      <= ST_MCU_WR_WAIT;
          mem_delay  <= ROM_WR_WAIT_MCU;
          rom_we_reg <= 1'b0;
        end
        ST_MCU_WR_WAIT: begin
          mem_delay <= mem_delay - 4'd1;
          if (mem_delay == 4'd0) begin
            rom_we_reg <= 1'b1;
            state      <= ST_MCU_WR_WAIT2;
            mem_delay  <= MCU_RECOVER_WAIT;
          end
        end
        ST_MCU_WR_WAIT2: begin
          mem_delay <= mem_delay - 4'd1;
          if (mem_delay == 4'd0) begin
            state <= ST_MCU_WR_END;
          end
        end
        ST_MCU_WR_END: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and data latches
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if ((cycle_start || wr_start) && is_cart) begin
      rom_addr_reg <= mapped_addr;
    end else if (state == ST_IDLE) begin
      rom_addr_reg <= mapped_addr;
    end else if ((state == ST_MCU_RD_ADDR) || (state == ST_MCU_WR_ADDR)) begin
      rom_addr_reg <= mcu_addr;
    end

    if (state == ST_SNES_WR_DATA) begin
      rom_wr_data <= snes_data_in;
    end else if (state == ST_MCU_WR_ADDR) begin
      rom_wr_data <= mcu_dout;
    end

    // Read byte tracks the bus until the end state
    if ((state == ST_SNES_RD_WAIT) || (state == ST_SNES_RD_END)) begin
      snes_rd_data <= rom_rd_byte;
    end

    if ((state == ST_MCU_RD_WAIT) && (mem_delay == 4'd0)) begin
      mcu_din <= rom_rd_byte;
    end
  end

endmodule

//--- rom_bus_drive.sv
`timescale 1ns/10ps

module rom_bus_drive (
  input  cart_mem_pkg::snes_addr_t     mapped_addr,
  input  cart_mem_pkg::snes_addr_t     rom_addr_reg,
  input  logic                         assert_snes_addr,
  input  logic                         rom_we,
  input  cart_mem_pkg::byte_t          rom_wr_data,
  input  cart_mem_pkg::byte_t          snes_rd_data,
  input  logic                         snes_read,
  input  logic                         snes_write,
  input  logic                         is_cart,
  output cart_mem_pkg::rom_word_addr_t rom_addr,
  output logic                         rom_byte_sel,
  output cart_mem_pkg::rom_word_t      rom_data_out,
  output logic                         rom_data_oe,
  output logic                         rom_bhe,
  output logic                         rom_ble,
  output cart_mem_pkg::byte_t          snes_data_out,
  output logic                         snes_data_oe,
  output logic                         snes_databus_oe,
  output logic                         snes_databus_dir
);

  import cart_mem_pkg::*;

  snes_addr_t bus_addr;

  ////////////////////////////////////////////////////////////
  // PSRAM side
  ////////////////////////////////////////////////////////////

  assign bus_addr = assert_snes_addr ? mapped_addr : rom_addr_reg;

  assign rom_addr     = bus_addr[23:1];
  assign rom_byte_sel = bus_addr[0];

  // Odd byte sits on the low lane
  assign rom_data_out = rom_byte_sel ? {8'h00, rom_wr_data} : {rom_wr_data, 8'h00};
  assign rom_data_oe  = ~rom_we;

  // Active low lane selects mask the idle lane only while writing
  assign rom_bhe = ~rom_we ? rom_byte_sel : 1'b0;
  assign rom_ble = ~rom_we ? ~rom_byte_sel : 1'b0;

  ////////////////////////////////////////////////////////////
  // Console data bus
  ////////////////////////////////////////////////////////////

  assign snes_data_out = snes_rd_data;
  assign snes_data_oe  = ~snes_read;

  // Transceiver on for a cartridge hit with either strobe
  assign snes_databus_oe  = ~is_cart | (snes_read & snes_write);
  assign snes_databus_dir = ~snes_read;

endmodule

//--- cart_mem_top.sv
`timescale 1ns/10ps

module cart_mem_top (
  input  logic                         CLK2,
  input  logic                         rst_n,
  input  logic                         snes_read,
  input  logic                         snes_write,
  input  logic                         snes_cpu_clk,
  input  cart_mem_pkg::snes_addr_t     mapped_addr,
  input  logic                         is_cart,
  input  logic                         is_writable,
  input  cart_mem_pkg::byte_t          snes_data_in,
  output cart_mem_pkg::byte_t          snes_data_out,
  output logic                         snes_data_oe,
  output logic                         snes_databus_oe,
  output logic                         snes_databus_dir,
  input  logic                         mcu_rrq,
  input  logic                         mcu_wrq,
  input  cart_mem_pkg::snes_addr_t     mcu_addr,
  input  cart_mem_pkg::byte_t          mcu_dout,
  output cart_mem_pkg::byte_t          mcu_din,
  output logic                         mcu_rdy,
  output cart_mem_pkg::rom_word_addr_t rom_addr,
  input  cart_mem_pkg::rom_word_t      rom_data_in,
  output cart_mem_pkg::rom_word_t      rom_data_out,
  output logic                         rom_data_oe,
  output logic                         rom_ce,
  output logic                         rom_oe,
  output logic                         rom_we,
  output logic                         rom_bhe,
  output logic                         rom_ble
);

  import cart_mem_pkg::*;

  logic       wr_start;
  logic       cycle_start;
  logic       cycle_end;
  logic       mcu_rd_pend;
  logic       mcu_wr_pend;
  logic       mcu_done;
  logic       assert_snes_addr;
  logic       rom_byte_sel;
  snes_addr_t rom_addr_reg;
  byte_t      rom_wr_data;
  byte_t      snes_rd_data;

  // Chip always selected while WE overrides the read enable
  assign rom_ce = 1'b0;
  assign rom_oe = 1'b0;

  snes_bus_sync i_snes_bus_sync (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_write   (snes_write),
    .snes_cpu_clk (snes_cpu_clk),
    .wr_start     (wr_start),
    .cycle_start  (cycle_start),
    .cycle_end    (cycle_end)
  );

  mcu_req_ctrl i_mcu_req_ctrl (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .mcu_rrq     (mcu_rrq),
    .mcu_wrq     (mcu_wrq),
    .mcu_done    (mcu_done),
    .mcu_rd_pend (mcu_rd_pend),
    .mcu_wr_pend (mcu_wr_pend),
    .mcu_rdy     (mcu_rdy)
  );

  rom_arbiter i_rom_arbiter (
    .CLK2             (CLK2),
    .rst_n            (rst_n),
    .wr_start         (wr_start),
    .cycle_start      (cycle_start),
    .cycle_end        (cycle_end),
    .snes_cpu_clk     (snes_cpu_clk),
    .is_cart          (is_cart),
    .is_writable      (is_writable),
    .mapped_addr      (mapped_addr),
    .snes_data_in     (snes_data_in),
    .mcu_rd_pend      (mcu_rd_pend),
    .mcu_wr_pend      (mcu_wr_pend),
    .mcu_addr         (mcu_addr),
    .mcu_dout         (mcu_dout),
    .rom_data_in      (rom_data_in),
    .rom_byte_sel     (rom_byte_sel),
    .rom_addr_reg     (rom_addr_reg),
    .assert_snes_addr (assert_snes_addr),
    .rom_we           (rom_we),
    .rom_wr_data      (rom_wr_data),
    .snes_rd_data     (snes_rd_data),
    .mcu_din          (mcu_din),
    .mcu_done         (mcu_done)
  );

  rom_bus_drive i_rom_bus_drive (
    .mapped_addr      (mapped_addr),
    .rom_addr_reg     (rom_addr_reg),
    .assert_snes_addr (assert_snes_addr),
    .rom_we           (rom_we),
    .rom_wr_data      (rom_wr_data),
    .snes_rd_data     (snes_rd_data),
    .snes_read        (snes_read),
    .snes_write       (snes_write),
    .is_cart          (is_cart),
    .rom_addr         (rom_addr),
    .rom_byte_sel     (rom_byte_sel),
    .rom_data_out     (rom_data_out),
    .rom_data_oe      (rom_data_oe),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .snes_data_out    (snes_data_out),
    .snes_data_oe     (snes_data_oe),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir)
  );

endmodule

//--- tb_psram_model.sv
`timescale 1ns/10ps

module tb_psram_model (
  input  logic                         CLK2,
  input  logic                         rom_ce,
  input  logic                         rom_we,
  input  logic                         rom_bhe,
  input  logic                         rom_ble,
  input  cart_mem_pkg::rom_word_addr_t rom_addr,
  input  cart_mem_pkg::rom_word_t      wr_data,
  output cart_mem_pkg::rom_word_t      rd_data
);

  import cart_mem_pkg::*;

  localparam int DEPTH = 4096;

  rom_word_t   mem [DEPTH];
  logic [11:0] idx;

  // Only the low word address bits reach the array
  assign idx     = rom_addr[11:0];
  assign rd_data = mem[idx];

  // Fill from the whole word index
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] <= 16'(i) * 16'h9e37 + 16'h1f2b;
    end
  end

  always_ff @(posedge CLK2) begin
    if (!rom_ce && !rom_we) begin
      if (!rom_bhe) begin
        mem[idx][15:8] <= wr_data[15:8];
      end
      if (!rom_ble) begin
        mem[idx][7:0] <= wr_data[7:0];
      end
    end
  end

endmodule

//--- tb_cart_mem_top.sv
`timescale 1ns/10ps

module tb_cart_mem_top;

  import cart_mem_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 10;
  localparam int N_MCU_WR     = 24;
  localparam int N_MCU_RD     = 24;
  localparam int N_SNES_RD    = 8;
  localparam int N_SNES_WR    = 4;
  localparam int N_MIXED      = 6;
  // Four accesses per console write round and two per mixed round
  localparam int N_TRANS = N_MCU_WR + N_MCU_RD + N_SNES_RD + 4 * N_SNES_WR + 2 * N_MIXED;
  localparam int WATCHDOG_CYCLES = 60 * N_TRANS + RESET_CYCLES;

  logic           CLK2;
  logic           rst_n;
  logic           snes_read;
  logic           snes_write;
  logic           snes_cpu_clk;
  snes_addr_t     mapped_addr;
  logic           is_cart;
  logic           is_writable;
  byte_t          snes_data_in;
  byte_t          snes_data_out;
  logic           snes_data_oe;
  logic           snes_databus_oe;
  logic           snes_databus_dir;
  logic           mcu_rrq;
  logic           mcu_wrq;
  snes_addr_t     mcu_addr;
  byte_t          mcu_dout;
  byte_t          mcu_din;
  logic           mcu_rdy;
  rom_word_addr_t rom_addr;
  rom_word_t      rom_data_in;
  rom_word_t      rom_data_out;
  logic           rom_data_oe;
  logic           rom_ce;
  logic           rom_oe;
  logic           rom_we;
  logic           rom_bhe;
  logic           rom_ble;

  logic [15:0] lfsr;
  byte_t       ref_mem [8192];
  snes_addr_t  wr_addrs [N_MCU_WR];

  cart_mem_top i_cart_mem_top (.*);

  tb_psram_model i_psram (
    .CLK2    (CLK2),
    .rom_ce  (rom_ce),
    .rom_we  (rom_we),
    .rom_bhe (rom_bhe),
    .rom_ble (rom_ble),
    .rom_addr(rom_addr),
    .wr_data (rom_data_out),
    .rd_data (rom_data_in)
  );

  ////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    CLK2 = 1'b0;
    forever #(CLK_PERIOD / 2) CLK2 = ~CLK2;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci taps of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [23:0] rand_bits(input int n);
    logic [23:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[22:0], fb};
    end
    return r;
  endfunction

  // Odd byte on the low lane
  function automatic rom_word_t ref_word(input snes_addr_t a);
    return {ref_mem[{a[12:1], 1'b0}], ref_mem[{a[12:1], 1'b1}]};
  endfunction

  task automatic step();
    @(posedge CLK2);
    #DRIVE_DELAY;
  endtask

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s = %h, expected %h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  task automatic mcu_access(input logic wr, input snes_addr_t a, input byte_t d);
    int we_low;
    int oe_on;
    int exp_low;
    we_low   = 0;
    oe_on    = 0;
    exp_low  = wr ? int'(ROM_WR_WAIT_MCU) + 1 : 0;
    mcu_addr = a;
    mcu_dout = d;
    mcu_wrq  = wr;
    mcu_rrq  = ~wr;
    step();
    mcu_wrq = 1'b0;
    mcu_rrq = 1'b0;
    compare("mcu_rdy", 16'(mcu_rdy), 16'h0000);
    while (mcu_rdy !== 1'b1) begin
      if (rom_we === 1'b0) begin
        we_low++;
      end
      if (rom_data_oe === 1'b1) begin
        oe_on++;
      end
      step();
    end
    // Write pulse and PSRAM data drive span the same wait cycles
    compare("rom_we_low_cycles", 16'(we_low), 16'(exp_low));
    compare("rom_data_oe_cycles", 16'(oe_on), 16'(exp_low));
  endtask

  // 8 low then 16 high CPU clock cycles with an optional MCU read at the rise
  task automatic snes_read_cycle(input snes_addr_t a, input logic with_mcu);
    mapped_addr  = a;
    is_cart      = 1'b1;
    snes_read    = 1'b0;
    snes_cpu_clk = 1'b0;
    repeat (8) step();
    snes_cpu_clk = 1'b1;
    mcu_rrq      = with_mcu;
    step();
    mcu_rrq = 1'b0;
    if (with_mcu) begin
      compare("mcu_rdy", 16'(mcu_rdy), 16'h0000);
    end
    repeat (15) step();
    compare("snes_data_out", 16'(snes_data_out), 16'(ref_mem[a[12:0]]));
    compare("snes_data_oe", 16'(snes_data_oe), 16'h0001);
    compare("snes_databus_dir", 16'(snes_databus_dir), 16'h0001);
    snes_read    = 1'b1;
    snes_cpu_clk = 1'b0;
  endtask

  task automatic snes_write_cycle(input snes_addr_t a, input byte_t d, input logic writable);
    mapped_addr  = a;
    snes_data_in = d;
    is_cart      = 1'b1;
    is_writable  = writable;
    snes_write   = 1'b0;
    repeat (8) step();
    compare("snes_databus_oe", 16'(snes_databus_oe), 16'h0000);
    compare("snes_databus_dir", 16'(snes_databus_dir), 16'h0000);
    repeat (8) step();
    snes_write  = 1'b1;
    is_writable = 1'b0;
    // Write history refills before the next strobe
    repeat (6) step();
    if (writable) begin
      ref_mem[a[12:0]] = d;
    end
    compare("psram_word", i_psram.mem[a[12:1]], ref_word(a));
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    snes_addr_t a;
    snes_addr_t m;
    byte_t      d;
    int         k;
    rst_n        = 1'b0;
    snes_read    = 1'b1;
    snes_write   = 1'b1;
    snes_cpu_clk = 1'b0;
    mapped_addr  = '0;
    is_cart      = 1'b0;
    is_writable  = 1'b0;
    snes_data_in = '0;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    mcu_addr     = '0;
    mcu_dout     = '0;
    lfsr         = 16'd25;
    repeat (RESET_CYCLES) @(posedge CLK2);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    repeat (4) step();

    compare("mcu_rdy", 16'(mcu_rdy), 16'h0001);
    compare("rom_we", 16'(rom_we), 16'h0001);
    compare("snes_data_oe", 16'(snes_data_oe), 16'h0000);
    compare("snes_databus_oe", 16'(snes_databus_oe), 16'h0001);
    compare("rom_ce", 16'(rom_ce), 16'h0000);
    compare("rom_oe", 16'(rom_oe), 16'h0000);
    compare("rom_data_oe", 16'(rom_data_oe), 16'h0000);

    // Mirror the PSRAM fill
    for (int w = 0; w < 4096; w++) begin
      ref_mem[{w[11:0], 1'b0}] = i_psram.mem[w][15:8];
      ref_mem[{w[11:0], 1'b1}] = i_psram.mem[w][7:0];
    end

    for (int i = 0; i < N_MCU_WR; i++) begin
      a           = rand_bits(24);
      d           = byte_t'(rand_bits(8));
      wr_addrs[i] = a;
      mcu_access(1'b1, a, d);
      ref_mem[a[12:0]] = d;
      compare("psram_word", i_psram.mem[a[12:1]], ref_word(a));
    end

    for (int i = 0; i < N_MCU_RD; i++) begin
      k = int'(rand_bits(5)) % N_MCU_WR;
      a = wr_addrs[k];
      mcu_access(1'b0, a, 8'h00);
      compare("mcu_din", 16'(mcu_din), 16'(ref_mem[a[12:0]]));
    end

    for (int i = 0; i < N_SNES_RD; i++) begin
      snes_read_cycle(rand_bits(24), 1'b0);
    end

    for (int i = 0; i < N_SNES_WR; i++) begin
      a = rand_bits(24);
      d = byte_t'(rand_bits(8));
      snes_write_cycle(a, d, 1'b1);
      mcu_access(1'b0, a, 8'h00);
      compare("mcu_din", 16'(mcu_din), 16'(ref_mem[a[12:0]]));
      snes_read_cycle(a, 1'b0);
      snes_write_cycle(a, ~d, 1'b0);
    end

    // MCU reads preempted by running console cycles
    for (int i = 0; i < N_MIXED; i++) begin
      a        = rand_bits(24);
      m        = rand_bits(24);
      mcu_addr = m;
      snes_read_cycle(a, 1'b1);
      while (mcu_rdy !== 1'b1) begin
        step();
      end
      compare("mcu_din", 16'(mcu_din), 16'(ref_mem[m[12:0]]));
    end

    repeat (4) step();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- vlog.f
cart_mem_pkg.sv
snes_bus_sync.sv
mcu_req_ctrl.sv
rom_arbiter.sv
rom_bus_drive.sv
cart_mem_top.sv
tb_psram_model.sv
tb_cart_mem_top.sv

//--- Makefile
# Verilator build and run of the cartridge memory arbiter testbench

TOP = tb_cart_mem_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG); grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
